// File: verilog/rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int alu_op_w   = 4;
  localparam int cmp_op_w   = 3;

  // Major opcodes
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_system  = 7'b1110011;

  localparam logic [6:0] funct7_alt = 7'b0100000; // SUB, SRA, SRAI

  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  // Same values as the branch funct3 field
  localparam logic [cmp_op_w-1:0] cmp_eq  = 3'b000;
  localparam logic [cmp_op_w-1:0] cmp_ne  = 3'b001;
  localparam logic [cmp_op_w-1:0] cmp_lt  = 3'b100;
  localparam logic [cmp_op_w-1:0] cmp_ge  = 3'b101;
  localparam logic [cmp_op_w-1:0] cmp_ltu = 3'b110;
  localparam logic [cmp_op_w-1:0] cmp_geu = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, six views of it
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_t;

endpackage

// File: verilog/rv_alu.sv
module rv_alu (
  input  logic [rv_pkg::xlen-1:0]     rs1_data,
  input  logic [rv_pkg::xlen-1:0]     rs2_data,
  input  logic [rv_pkg::xlen-1:0]     pc,
  input  logic [rv_pkg::xlen-1:0]     imm,
  input  logic                        a_sel_pc,
  input  logic                        b_sel_imm,
  input  logic [rv_pkg::alu_op_w-1:0] alu_op,
  input  logic [rv_pkg::cmp_op_w-1:0] cmp_op,
  output logic [rv_pkg::xlen-1:0]     result,
  output logic                        cmp_true
);

  logic [rv_pkg::xlen-1:0] a;
  logic [rv_pkg::xlen-1:0] b;
  logic [4:0] shamt;

  assign a     = a_sel_pc ? pc : rs1_data;  // PC for AUIPC
  assign b     = b_sel_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_slt:    result = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu:   result = {31'd0, a < b};
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_pass_b: result = b; // LUI
      default:            result = a + b;
    endcase
  end

  // Branch compare always works on the two registers
  always_comb begin
    case (cmp_op)
      rv_pkg::cmp_eq:  cmp_true = (rs1_data == rs2_data);
      rv_pkg::cmp_ne:  cmp_true = (rs1_data != rs2_data);
      rv_pkg::cmp_lt:  cmp_true = $signed(rs1_data) < $signed(rs2_data);
      rv_pkg::cmp_ge:  cmp_true = $signed(rs1_data) >= $signed(rs2_data);
      rv_pkg::cmp_ltu: cmp_true = (rs1_data < rs2_data);
      rv_pkg::cmp_geu: cmp_true = (rs1_data >= rs2_data);
      default:         cmp_true = 1'b0;
    endcase
  end

endmodule

// File: verilog/rv_decode.sv
module rv_decode (
  input  rv_pkg::insn_t                   insn,
  output logic [rv_pkg::reg_addr_w-1:0]   rs1_addr,
  output logic [rv_pkg::reg_addr_w-1:0]   rs2_addr,
  output logic [rv_pkg::reg_addr_w-1:0]   rd_addr,
  output logic [rv_pkg::xlen-1:0]         imm,
  output logic [rv_pkg::alu_op_w-1:0]     alu_op,
  output logic [rv_pkg::cmp_op_w-1:0]     cmp_op,
  output logic                            a_sel_pc,
  output logic                            b_sel_imm,
  output logic                            is_branch,
  output logic                            is_jal,
  output logic                            is_jalr,
  output logic                            is_load,
  output logic                            is_store,
  output logic                            is_ecall,
  output logic                            writes_rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [6:0] shamt_hi;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;

  // Shared decode of funct3 into an ALU op, alt picks SUB or SRA
  function automatic logic [rv_pkg::alu_op_w-1:0] alu_from_f3(input logic [2:0] f3,
                                                              input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  assign opcode   = insn.r_fmt.opcode;
  assign funct3   = insn.r_fmt.funct3;
  assign funct7   = insn.r_fmt.funct7;
  assign shamt_hi = insn.i_fmt.imm[11:5];
  assign rs1_addr = insn.r_fmt.rs1;
  assign rs2_addr = insn.r_fmt.rs2;
  assign rd_addr  = insn.r_fmt.rd;

  assign imm_i = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  assign imm_s = {{20{insn.s_fmt.imm_hi[6]}}, insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
  assign imm_b = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                  insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm, 12'b0};
  assign imm_j = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                  insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    imm       = imm_i;
    alu_op    = rv_pkg::alu_add;
    cmp_op    = rv_pkg::cmp_eq;
    a_sel_pc  = 1'b0;
    b_sel_imm = 1'b1;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_ecall  = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        imm       = imm_u;
        alu_op    = rv_pkg::alu_pass_b;
        writes_rd = 1'b1;
      end
      rv_pkg::op_auipc: begin
        imm       = imm_u;
        a_sel_pc  = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jal: begin
        imm       = imm_j;
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jalr: begin
        is_jalr   = (funct3 == 3'b000);
        writes_rd = (funct3 == 3'b000);
      end
      rv_pkg::op_branch: begin
        imm       = imm_b;
        cmp_op    = funct3;
        is_branch = (funct3[2:1] != 2'b01); // 010 and 011 are not branches
      end
      rv_pkg::op_load: begin
        is_load   = (funct3 == 3'b010); // LW only
        writes_rd = (funct3 == 3'b010);
      end
      rv_pkg::op_store: begin
        imm      = imm_s;
        is_store = (funct3 == 3'b010);
      end
      rv_pkg::op_reg_imm: begin
        alu_op = alu_from_f3(funct3, funct3 == 3'b101 && insn.i_fmt.imm[10]);
        writes_rd = (funct3[1:0] != 2'b01) || (shamt_hi == 7'd0) ||
                    (funct3 == 3'b101 && shamt_hi == rv_pkg::funct7_alt);
      end
      rv_pkg::op_reg_reg: begin
        b_sel_imm = 1'b0;
        alu_op    = alu_from_f3(funct3, insn.r_fmt.funct7[5]);
        writes_rd = (funct7 == 7'd0) ||
                    (funct7 == rv_pkg::funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv_pkg::op_system: begin
        is_ecall = (insn.i_fmt.imm == 12'd0) && (insn.i_fmt.rs1 == 5'd0) &&
                   (insn.i_fmt.funct3 == 3'd0) && (insn.i_fmt.rd == 5'd0);
      end
      default: begin
        // Unsupported, no write and PC + 4
      end
    endcase
  end

endmodule

// File: verilog/rv_regfile.sv
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                          rd_we,
  input  logic [rv_pkg::xlen-1:0]       rd_wdata,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [1:31]; // No storage for x0

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_addr != '0) begin
      regs[rd_addr] <= rd_wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: verilog/rv_control.sv
module rv_control #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wb_ack,
  input  logic [rv_pkg::xlen-1:0] wb_rdata,
  input  logic                    is_branch,
  input  logic                    is_jal,
  input  logic                    is_jalr,
  input  logic                    is_load,
  input  logic                    is_store,
  input  logic                    is_ecall,
  input  logic                    writes_rd,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic [rv_pkg::xlen-1:0] alu_result,
  input  logic                    cmp_true,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::insn_t           insn,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output logic [rv_pkg::xlen-1:0] wb_adr,
  output logic [rv_pkg::xlen-1:0] wb_wdata,
  output logic                    rd_we,
  output logic [rv_pkg::xlen-1:0] rd_wdata,
  output logic                    halt
);

  localparam logic [1:0] st_fetch   = 2'd0;
  localparam logic [1:0] st_execute = 2'd1;
  localparam logic [1:0] st_mem     = 2'd2;
  localparam logic [1:0] st_halt    = 2'd3;

  logic [1:0] state;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] next_pc;
  logic fetch_start;
  logic fetch_done;
  logic mem_done;

  assign pc_plus4    = pc + 32'd4;
  assign fetch_start = (state == st_fetch) && !wb_cyc; // Bus idle, issue fetch
  assign fetch_done  = (state == st_fetch) && wb_cyc && wb_ack;
  assign mem_done    = (state == st_mem) && wb_ack;

  always_comb begin
    if (is_jalr) begin
      next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
    end else if (is_jal || (is_branch && cmp_true)) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4; // Also covers unsupported encodings
    end
  end

  // Loads write on the data ack, everything else at the end of execute
  assign rd_we = (state == st_execute && writes_rd && !is_load) || (mem_done && is_load);
  assign rd_wdata = is_load ? wb_rdata : (is_jal || is_jalr) ? pc_plus4 : alu_result;
  assign halt = (state == st_halt);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_fetch;
      pc     <= reset_pc;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (fetch_start) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= 1'b0;
          end else if (fetch_done) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            state  <= st_execute;
          end
        end
        st_execute: begin
          if (is_ecall) begin
            state <= st_halt;
          end else if (is_load || is_store) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= is_store;
            state  <= st_mem;
          end else begin
            pc    <= next_pc;
            state <= st_fetch;
          end
        end
        st_mem: begin
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            pc     <= pc_plus4;
            state  <= st_fetch;
          end
        end
        default: begin
          // Halted until reset
        end
      endcase
    end
  end

  // Instruction register and bus payload
  always_ff @(posedge clk) begin
    if (fetch_done) begin
      insn <= wb_rdata;
    end
    if (fetch_start) begin
      wb_adr <= pc;
    end else if (state == st_execute) begin
      wb_adr   <= alu_result; // Effective address of LW/SW
      wb_wdata <= rs2_data;
    end
  end

endmodule

// File: verilog/rv_core.sv
module rv_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    halt,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output logic [rv_pkg::xlen-1:0] wb_adr,
  output logic [rv_pkg::xlen-1:0] wb_wdata,
  input  logic [rv_pkg::xlen-1:0] wb_rdata,
  input  logic                    wb_ack
);

  rv_pkg::insn_t insn;
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] rd_wdata;
  logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
  logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
  logic [rv_pkg::reg_addr_w-1:0] rd_addr;
  logic [rv_pkg::alu_op_w-1:0] alu_op;
  logic [rv_pkg::cmp_op_w-1:0] cmp_op;
  logic a_sel_pc;
  logic b_sel_imm;
  logic cmp_true;
  logic rd_we;
  logic is_branch;
  logic is_jal;
  logic is_jalr;
  logic is_load;
  logic is_store;
  logic is_ecall;
  logic writes_rd;

  rv_control #(
    .reset_pc (reset_pc)
  ) i_rv_control (
    .clk        (clk),
    .rst        (rst),
    .wb_ack     (wb_ack),
    .wb_rdata   (wb_rdata),
    .is_branch  (is_branch),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .is_load    (is_load),
    .is_store   (is_store),
    .is_ecall   (is_ecall),
    .writes_rd  (writes_rd),
    .imm        (imm),
    .alu_result (alu_result),
    .cmp_true   (cmp_true),
    .rs2_data   (rs2_data),
    .insn       (insn),
    .pc         (pc),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_wdata   (wb_wdata),
    .rd_we      (rd_we),
    .rd_wdata   (rd_wdata),
    .halt       (halt)
  );

  rv_decode i_rv_decode (
    .insn      (insn),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr),
    .imm       (imm),
    .alu_op    (alu_op),
    .cmp_op    (cmp_op),
    .a_sel_pc  (a_sel_pc),
    .b_sel_imm (b_sel_imm),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_load   (is_load),
    .is_store  (is_store),
    .is_ecall  (is_ecall),
    .writes_rd (writes_rd)
  );

  rv_alu i_rv_alu (
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc        (pc),
    .imm       (imm),
    .a_sel_pc  (a_sel_pc),
    .b_sel_imm (b_sel_imm),
    .alu_op    (alu_op),
    .cmp_op    (cmp_op),
    .result    (alu_result),
    .cmp_true  (cmp_true)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_we    (rd_we),
    .rd_wdata (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

// File: test/tb_wb_mem.sv
module tb_wb_mem #(
  parameter int words = 1024
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        wait_en,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [31:0] adr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        ack
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int aw = $clog2(words);

  logic [31:0] mem [0:words-1];
  logic [31:0] log_adr [0:255];   // Every write in arrival order
  logic [31:0] log_data [0:255];
  int log_count = 0;
  int hold_errors = 0;            // Requests that changed before ack
  integer seed = 86;
  logic busy;
  int wait_left;
  int delay;
  logic [31:0] req_adr;
  logic [31:0] req_wdata;
  logic req_we;

  initial begin
    ack   = 1'b0;
    rdata = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      ack  <= 1'b0;
      busy <= 1'b0;
    end else if (cyc && stb && !ack) begin
      if (busy) begin
        delay = wait_left;
        if (adr !== req_adr || we !== req_we || (we && wdata !== req_wdata)) begin
          hold_errors <= hold_errors + 1;
        end
      end else begin
        delay = wait_en ? {$random(seed)} % 4 : 0; // 0 to 3 wait cycles
        req_adr   <= adr;
        req_we    <= we;
        req_wdata <= wdata;
      end
      if (delay == 0) begin
        ack   <= 1'b1;
        busy  <= 1'b0;
        rdata <= mem[adr[aw+1:2]];
        if (we) begin
          mem[adr[aw+1:2]] <= wdata;
          if (log_count < 256) begin
            log_adr[log_count]  <= adr;
            log_data[log_count] <= wdata;
          end
          log_count <= log_count + 1;
        end
      end else begin
        busy      <= 1'b1;
        wait_left <= delay - 1;
      end
    end else begin
      ack <= 1'b0; // Single-cycle ack
    end
  end

endmodule

// File: test/tb_rv_core.sv
module tb_rv_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] reset_pc  = 32'h0000_0100;
  localparam int          mem_words = 1024;
  localparam logic [31:0] ecall     = 32'h0000_0073;

  // Operands of the ALU program
  localparam logic [31:0] op_a = 32'h1234_5678;
  localparam logic [31:0] op_b = 32'hFFFF_FFF9;
  localparam logic [31:0] op_c = 32'h8000_0000;
  localparam logic [31:0] op_d = 32'd5;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic wait_en = 1'b0;
  logic halt;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic wb_ack;
  logic [31:0] wb_adr;
  logic [31:0] wb_wdata;
  logic [31:0] wb_rdata;

  logic [31:0] emit_ptr;
  logic [31:0] data_base;
  logic [31:0] exp_adr [0:63];
  logic [31:0] exp_val [0:63];
  int exp_count;
  int slot;
  int emitted = 0;
  int cycles = 0;

  always #5 clk = ~clk;

  rv_core #(
    .reset_pc (reset_pc)
  ) i_rv_core (
    .clk      (clk),
    .rst      (rst),
    .halt     (halt),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

  tb_wb_mem #(
    .words (mem_words)
  ) i_wb_mem (
    .clk     (clk),
    .rst     (rst),
    .wait_en (wait_en),
    .cyc     (wb_cyc),
    .stb     (wb_stb),
    .we      (wb_we),
    .adr     (wb_adr),
    .wdata   (wb_wdata),
    .rdata   (wb_rdata),
    .ack     (wb_ack)
  );

  // At most 11 cycles per instruction, margin for resets and idle checks
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > emitted * 11 + 400) begin
      $display("Timeout after %0d cycles, the core did not reach halt", cycles);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return 32'hA500_0000 ^ addr;
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, 7'b0010011);
  endfunction

  function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return i_type(imm, rs1, f3, rd, 7'b0010011);
  endfunction

  function automatic logic [31:0] op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] off);
    return i_type(off, rs1, 3'b010, rd, 7'b0000011);
  endfunction

  function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] auipc(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0010111};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] off);
    return i_type(off, rs1, 3'b000, rd, 7'b1100111);
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] slot_addr();
    return data_base + 32'(slot * 4);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s is %h, expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic start_program(input logic [31:0] base);
    for (int i = 0; i < mem_words; i++) begin
      i_wb_mem.mem[i] = fill_word(32'(i * 4));
    end
    emit_ptr  = reset_pc;
    data_base = base;
    exp_count = 0;
    slot      = 0;
  endtask

  task automatic emit(input logic [31:0] insn);
    i_wb_mem.mem[emit_ptr[11:2]] = insn;
    emit_ptr = emit_ptr + 32'd4;
    emitted++;
  endtask

  task automatic expect_word(input logic [31:0] addr, input logic [31:0] val);
    exp_adr[exp_count] = addr;
    exp_val[exp_count] = val;
    exp_count++;
  endtask

  // SW of one register to the next result slot off x10
  task automatic store_slot(input logic [4:0] rs, input logic [31:0] exp);
    emit(sw(rs, 5'd10, 12'(slot * 4)));
    expect_word(slot_addr(), exp);
    slot++;
  endtask

  task automatic op_result(input logic [31:0] insn, input logic [31:0] exp);
    emit(insn); // Always targets x5
    store_slot(5'd5, exp);
  endtask

  task automatic check_bus_idle();
    check_value("halt", halt, 1'b0);
    check_value("wb_cyc", wb_cyc, 1'b0);
    check_value("wb_we", wb_we, 1'b0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_bus_idle();
      end
      @(posedge clk);
    end
    rst <= 1'b0;
    @(negedge clk);
    check_bus_idle(); // First cycle with rst low
  endtask

  task automatic run_program();
    apply_reset();
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic check_expected();
    for (int i = 0; i < exp_count; i++) begin
      check_value($sformatf("mem[%h]", exp_adr[i]), i_wb_mem.mem[exp_adr[i][11:2]],
                  exp_val[i]);
    end
    check_value("wb hold errors", i_wb_mem.hold_errors, 32'd0);
  endtask

  task automatic test_reset();
    start_program(32'h400);
    emit(ecall);
    apply_reset();
    @(negedge clk);
    check_value("wb_cyc", wb_cyc, 1'b1);
    check_value("wb_stb", wb_stb, 1'b1);
    check_value("wb_we", wb_we, 1'b0);
    check_value("wb_adr", wb_adr, reset_pc);
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic build_alu_program();
    start_program(32'h400);
    emit(lui(5'd1, 20'h12345));
    emit(addi(5'd1, 5'd1, 12'h678));
    emit(addi(5'd2, 5'd0, 12'hFF9));
    emit(lui(5'd3, 20'h80000));
    emit(addi(5'd4, 5'd0, 12'h005));
    emit(addi(5'd10, 5'd0, 12'h400));
    op_result(addi(5'd5, 5'd1, 12'hFF0), op_a - 32'd16);
    op_result(op_imm(3'b010, 5'd5, 5'd2, 12'hFFA), 32'd1);   // -7 < -6
    op_result(op_imm(3'b010, 5'd5, 5'd1, 12'h005), 32'd0);
    op_result(op_imm(3'b011, 5'd5, 5'd2, 12'hFFF), 32'd1);   // Unsigned vs all ones
    op_result(op_imm(3'b100, 5'd5, 5'd1, 12'hFFF), ~op_a);
    op_result(op_imm(3'b110, 5'd5, 5'd1, 12'h0F0), op_a | 32'h0F0);
    op_result(op_imm(3'b111, 5'd5, 5'd1, 12'h7FF), op_a & 32'h7FF);
    op_result(op_imm(3'b001, 5'd5, 5'd1, 12'h004), op_a << 4);
    op_result(op_imm(3'b101, 5'd5, 5'd3, 12'h003), op_c >> 3);
    op_result(op_imm(3'b101, 5'd5, 5'd3, 12'h403), 32'hF000_0000); // SRAI
    op_result(op_reg(7'h00, 3'b000, 5'd5, 5'd1, 5'd2), op_a + op_b);
    op_result(op_reg(7'h20, 3'b000, 5'd5, 5'd1, 5'd2), op_a - op_b);
    op_result(op_reg(7'h00, 3'b001, 5'd5, 5'd1, 5'd4), op_a << 5);
    op_result(op_reg(7'h00, 3'b001, 5'd5, 5'd1, 5'd2), op_a << 25); // Low 5 bits only
    op_result(op_reg(7'h00, 3'b010, 5'd5, 5'd2, 5'd1), 32'd1);
    op_result(op_reg(7'h00, 3'b010, 5'd5, 5'd1, 5'd2), 32'd0);
    op_result(op_reg(7'h00, 3'b011, 5'd5, 5'd2, 5'd1), 32'd0);
    op_result(op_reg(7'h00, 3'b011, 5'd5, 5'd1, 5'd2), 32'd1);
    op_result(op_reg(7'h00, 3'b100, 5'd5, 5'd1, 5'd2), op_a ^ op_b);
    op_result(op_reg(7'h00, 3'b101, 5'd5, 5'd3, 5'd4), op_c >> 5);
    op_result(op_reg(7'h20, 3'b101, 5'd5, 5'd3, 5'd4), 32'hFC00_0000);
    op_result(op_reg(7'h00, 3'b110, 5'd5, 5'd1, 5'd2), op_a | op_b);
    op_result(op_reg(7'h00, 3'b111, 5'd5, 5'd1, 5'd2), op_a & op_b);
    op_result(lui(5'd5, 20'hABCDE), 32'hABCD_E000);
    op_result(auipc(5'd5, 20'h00001), emit_ptr + 32'h1000);
    // Write to x0 must not stick
    emit(addi(5'd0, 5'd1, 12'h07B));
    op_result(op_reg(7'h00, 3'b000, 5'd5, 5'd0, 5'd4), op_d);
    emit(ecall);
  endtask

  task automatic test_alu(input logic waits);
    @(posedge clk);
    wait_en <= waits;
    build_alu_program();
    run_program();
    check_expected();
  endtask

  task automatic test_load_store();
    int log_start;
    start_program(32'h400);
    log_start = i_wb_mem.log_count;
    emit(addi(5'd10, 5'd0, 12'h400));
    emit(lui(5'd1, 20'hCAFEB));
    emit(addi(5'd1, 5'd1, 12'h0EE));
    emit(lui(5'd2, 20'h13579));
    emit(addi(5'd2, 5'd2, 12'h2AC));
    emit(addi(5'd11, 5'd10, 12'h100));
    emit(sw(5'd1, 5'd10, 12'h000));
    emit(sw(5'd2, 5'd10, 12'h004));
    emit(lw(5'd3, 5'd10, 12'h000));
    emit(lw(5'd4, 5'd10, 12'h004));
    emit(sw(5'd3, 5'd10, 12'h040));
    emit(sw(5'd4, 5'd10, 12'h044));
    emit(sw(5'd4, 5'd11, 12'hFF8));    // Negative offset, 0x4F8
    emit(lw(5'd6, 5'd11, 12'hFF8));
    emit(sw(5'd6, 5'd10, 12'h048));
    emit(lw(5'd7, 5'd10, 12'h100));    // Untouched fill word
    emit(sw(5'd7, 5'd10, 12'h04C));
    emit(ecall);
    // In SW order, so the write log can be compared too
    expect_word(32'h400, 32'hCAFE_B0EE);
    expect_word(32'h404, 32'h1357_92AC);
    expect_word(32'h440, 32'hCAFE_B0EE);
    expect_word(32'h444, 32'h1357_92AC);
    expect_word(32'h4F8, 32'h1357_92AC);
    expect_word(32'h448, 32'h1357_92AC);
    expect_word(32'h44C, fill_word(32'h500));
    run_program();
    check_expected();
    check_value("write log count", i_wb_mem.log_count - log_start, exp_count);
    for (int i = 0; i < exp_count; i++) begin
      check_value("log adr", i_wb_mem.log_adr[log_start + i], exp_adr[i]);
      check_value("log data", i_wb_mem.log_data[log_start + i], exp_val[i]);
    end
  endtask

  // Fall-through marker, then the branch target marker
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic taken);
    emit(branch(f3, rs1, rs2, 13'd12));
    emit(addi(5'd5, 5'd0, 12'h100 + 12'(slot)));
    store_slot(5'd5, taken ? fill_word(slot_addr()) : 32'h100 + 32'(slot));
    emit(addi(5'd5, 5'd0, 12'h200 + 12'(slot)));
    store_slot(5'd5, 32'h200 + 32'(slot));
  endtask

  task automatic test_branches();
    logic [31:0] link;
    start_program(32'h600);
    emit(addi(5'd10, 5'd0, 12'h600));
    emit(addi(5'd1, 5'd0, 12'h005));
    emit(addi(5'd2, 5'd0, 12'hFFD)); // -3
    branch_case(3'b000, 5'd1, 5'd1, 1'b1);
    branch_case(3'b000, 5'd1, 5'd2, 1'b0);
    branch_case(3'b001, 5'd1, 5'd2, 1'b1);
    branch_case(3'b001, 5'd1, 5'd1, 1'b0);
    branch_case(3'b100, 5'd2, 5'd1, 1'b1);
    branch_case(3'b100, 5'd1, 5'd2, 1'b0);
    branch_case(3'b101, 5'd1, 5'd2, 1'b1);
    branch_case(3'b101, 5'd2, 5'd1, 1'b0);
    branch_case(3'b110, 5'd1, 5'd2, 1'b1);
    branch_case(3'b110, 5'd2, 5'd1, 1'b0);
    branch_case(3'b111, 5'd2, 5'd1, 1'b1);
    branch_case(3'b111, 5'd1, 5'd2, 1'b0);
    link = emit_ptr + 32'd4;
    emit(jal(5'd6, 21'd12));
    emit(addi(5'd5, 5'd0, 12'h0EE));
    store_slot(5'd5, fill_word(slot_addr()));
    store_slot(5'd6, link);
    // JALR target is odd, bit 0 gets cleared
    link = emit_ptr + 32'd8;
    emit(auipc(5'd7, 20'h00000));
    emit(jalr(5'd8, 5'd7, 12'h011));
    emit(addi(5'd5, 5'd0, 12'h0EF));
    store_slot(5'd5, fill_word(slot_addr()));
    store_slot(5'd8, link);
    // PC must still be even after the JALR
    link = emit_ptr;
    emit(auipc(5'd9, 20'h00000));
    store_slot(5'd9, link);
    emit(ecall);
    run_program();
    check_expected();
  endtask

  task automatic test_halt();
    start_program(32'h700);
    emit(addi(5'd10, 5'd0, 12'h700));
    emit(addi(5'd5, 5'd0, 12'h02A));
    store_slot(5'd5, 32'h2A);
    emit(ecall);
    emit(addi(5'd5, 5'd0, 12'h055));
    store_slot(5'd5, fill_word(slot_addr())); // Never reached
    run_program();
    repeat (20) begin
      @(negedge clk);
      check_value("halt", halt, 1'b1);
      check_value("wb_cyc", wb_cyc, 1'b0);
    end
    check_expected();
  endtask

  initial begin
    test_reset();
    test_alu(1'b0);
    test_load_store();
    test_branches();
    test_alu(1'b1);   // Same program with random wait states
    test_halt();
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: flist.f
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_control.sv
verilog/rv_core.sv
test/tb_wb_mem.sv
test/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_alu.sv
  - verilog/rv_decode.sv
  - verilog/rv_regfile.sv
  - verilog/rv_control.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - test/tb_wb_mem.sv
      - test/tb_rv_core.sv
